// File: design/rv_pkg.sv
//////////////////////////////
// shared widths, opcodes, ALU codes and I/O addresses for tiny_rv
// imported by every design module
//////////////////////////////
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_sel_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_op_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;

    // branch conditions use the funct3 encoding directly
    localparam br_op_t BR_EQ  = 3'b000;
    localparam br_op_t BR_NE  = 3'b001;
    localparam br_op_t BR_LT  = 3'b100;
    localparam br_op_t BR_GE  = 3'b101;
    localparam br_op_t BR_LTU = 3'b110;
    localparam br_op_t BR_GEU = 3'b111;

    // funct3 of the arithmetic groups
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // only word loads and stores exist
    localparam logic [2:0] F3_WORD = 3'b010;
    // funct7 that selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // stores here are caught by the core and never reach the bus
    localparam addr_t OUT_ADDR  = 32'd1000;
    localparam addr_t HALT_ADDR = 32'd1004;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEM,
        HALTED
    } state_t;

endpackage

// File: design/rv_regfile.sv
//////////////////////////////
// 32 x 32 register file with two async read ports and one write port
// x0 always reads zero
//////////////////////////////
module rv_regfile (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_sel_t rs1_sel,
    input  rv_pkg::reg_sel_t rs2_sel,
    input  rv_pkg::reg_sel_t wr_sel,
    input  logic             wr_en,
    input  rv_pkg::word_t    wr_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    // x0 clears on reset and is never written
    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    // x0 must read zero even right after a write that targeted it
    assert property (@(posedge clk) disable iff (rst)
        (rs1_sel == '0) |-> (rs1_data == '0));

endmodule

// File: design/rv_alu.sv
//////////////////////////////
// arithmetic, logic, shift and compare unit
// also decides branches from the same operands
//////////////////////////////
module rv_alu (
    input  rv_pkg::word_t   alu_a,
    input  rv_pkg::word_t   alu_b,
    input  rv_pkg::alu_op_t alu_op,
    input  rv_pkg::br_op_t  br_op,
    output rv_pkg::word_t   alu_result,
    output logic            br_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    // shifts only look at the low five bits
    assign shamt = alu_b[4:0];

    assign lt_s = $signed(alu_a) < $signed(alu_b);
    assign lt_u = alu_a < alu_b;
    assign eq   = alu_a == alu_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLT:  alu_result = {31'b0, lt_s};
            ALU_SLTU: alu_result = {31'b0, lt_u};
            ALU_AND:  alu_result = alu_a & alu_b;
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SRL:  alu_result = alu_a >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            default:  alu_result = '0;
        endcase
    end

    // branch compare, signed or unsigned by funct3
    always_comb begin
        case (br_op)
            BR_EQ:   br_taken = eq;
            BR_NE:   br_taken = !eq;
            BR_LT:   br_taken = lt_s;
            BR_GE:   br_taken = !lt_s;
            BR_LTU:  br_taken = lt_u;
            BR_GEU:  br_taken = !lt_u;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// File: design/rv_control.sv
//////////////////////////////
// multi-cycle control with FSM, pc, instruction register and decoder
// plus the Wishbone classic master shared by fetch and data access
//////////////////////////////
module rv_control #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output rv_pkg::addr_t    wb_adr,
    output rv_pkg::word_t    wb_dat_w,
    input  rv_pkg::word_t    wb_dat_r,
    input  logic             wb_ack,
    output rv_pkg::reg_sel_t rs1_sel,
    output rv_pkg::reg_sel_t rs2_sel,
    output rv_pkg::reg_sel_t wr_sel,
    output logic             wr_en,
    output rv_pkg::word_t    wr_data,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    output rv_pkg::word_t    alu_a,
    output rv_pkg::word_t    alu_b,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::br_op_t   br_op,
    input  rv_pkg::word_t    alu_result,
    input  logic             br_taken,
    output rv_pkg::word_t    out_data,
    output logic             out_valid,
    output logic             halt
);
    import rv_pkg::*;

    state_t     state;
    state_t     state_nxt;
    addr_t      pc;
    addr_t      pc_nxt;
    addr_t      pc_plus4;
    instr_t     ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_sel_t   rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       illegal;
    logic       rd_write;
    logic       is_load;
    logic       is_store;
    logic       out_store;
    logic       halt_store;
    logic       bus_active;

    function automatic alu_op_t decode_alu(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    // instruction fields
    assign opcode  = ir[6:0];
    assign rd      = ir[11:7];
    assign funct3  = ir[14:12];
    assign rs1_sel = ir[19:15];
    assign rs2_sel = ir[24:20];
    assign funct7  = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    assign pc_plus4   = pc + 32'd4;
    assign is_load    = opcode == OP_LOAD;
    assign is_store   = opcode == OP_STORE;
    assign out_store  = is_store && alu_result == OUT_ADDR;
    assign halt_store = is_store && alu_result == HALT_ADDR;

    // anything outside the supported RV32I subset stops the core
    always_comb begin
        case (opcode)
            OP_IMM: begin
                illegal = (funct3 == F3_SLL && funct7 != 7'b0) ||
                          (funct3 == F3_SR && funct7 != 7'b0 && funct7 != F7_ALT);
            end
            OP_REG: begin
                illegal = !(funct7 == 7'b0 ||
                            (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
            end
            OP_LOAD, OP_STORE: illegal = funct3 != F3_WORD;
            OP_BRANCH: begin
                illegal = !(funct3 == BR_EQ || funct3 == BR_NE || funct3 == BR_LT ||
                            funct3 == BR_GE || funct3 == BR_LTU || funct3 == BR_GEU);
            end
            OP_JALR: illegal = funct3 != F3_ADD;
            OP_LUI, OP_AUIPC, OP_JAL: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    // loads, stores and JALR use the ALU for base + offset
    always_comb begin
        alu_a  = rs1_data;
        alu_b  = rs2_data;
        alu_op = ALU_ADD;
        case (opcode)
            OP_IMM: begin
                alu_b  = imm_i;
                alu_op = decode_alu(funct3, funct3 == F3_SR && funct7[5]);
            end
            OP_REG: alu_op = decode_alu(funct3, funct7[5]);
            OP_LOAD, OP_JALR: alu_b = imm_i;
            OP_STORE: alu_b = imm_s;
            default: alu_op = ALU_ADD;
        endcase
    end

    assign br_op = funct3;

    // writeback source
    always_comb begin
        wr_data  = alu_result;
        rd_write = 1'b0;
        case (opcode)
            OP_IMM, OP_REG: rd_write = 1'b1;
            OP_LUI: begin
                rd_write = 1'b1;
                wr_data  = imm_u;
            end
            OP_AUIPC: begin
                rd_write = 1'b1;
                wr_data  = pc + imm_u;
            end
            OP_JAL, OP_JALR: begin
                rd_write = 1'b1;
                wr_data  = pc_plus4;
            end
            // written in MEM on the ack edge
            OP_LOAD: wr_data = wb_dat_r;
            default: rd_write = 1'b0;
        endcase
    end

    assign wr_sel = rd;
    assign wr_en  = (state == EXECUTE && rd_write && !illegal) ||
                    (state == MEM && is_load && wb_ack);

    always_comb begin
        state_nxt = state;
        pc_nxt    = pc;
        case (state)
            FETCH: begin
                if (wb_ack) begin
                    state_nxt = EXECUTE;
                end
            end
            EXECUTE: begin
                state_nxt = FETCH;
                pc_nxt    = pc_plus4;
                if (illegal || halt_store) begin
                    state_nxt = HALTED;
                    pc_nxt    = pc;
                end else if (is_load || (is_store && !out_store)) begin
                    state_nxt = MEM;
                    pc_nxt    = pc;
                end else if (opcode == OP_JAL) begin
                    pc_nxt = pc + imm_j;
                end else if (opcode == OP_JALR) begin
                    pc_nxt = {alu_result[31:1], 1'b0};
                end else if (opcode == OP_BRANCH && br_taken) begin
                    pc_nxt = pc + imm_b;
                end
            end
            MEM: begin
                if (wb_ack) begin
                    state_nxt = FETCH;
                    pc_nxt    = pc_plus4;
                end
            end
            default: state_nxt = HALTED;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && wb_ack) begin
            ir <= wb_dat_r;
        end
    end

    // no request while reset is held, the first fetch follows its release
    // registers and ir are frozen in MEM, so the ALU address holds steady
    assign bus_active = !rst && (state == FETCH || state == MEM);
    assign wb_cyc     = bus_active;
    assign wb_stb     = bus_active;
    assign wb_we      = state == MEM && is_store;
    assign wb_adr     = (state == MEM) ? alu_result : pc;
    assign wb_dat_w   = rs2_data;

    assign out_valid = state == EXECUTE && out_store && !illegal;
    assign out_data  = rs2_data;
    assign halt      = state == HALTED;

    // a request is held until the slave acks it
    assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> wb_stb);

    // the request must not move while the slave inserts wait states
    assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> $stable(wb_adr));

endmodule

// File: design/rv_core.sv
//////////////////////////////
// tiny_rv top level, control unit with register file and ALU
//////////////////////////////
module rv_core #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::addr_t wb_adr,
    output rv_pkg::word_t wb_dat_w,
    input  rv_pkg::word_t wb_dat_r,
    input  logic          wb_ack,
    output rv_pkg::word_t out_data,
    output logic          out_valid,
    output logic          halt
);
    import rv_pkg::*;

    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    reg_sel_t wr_sel;
    logic     wr_en;
    word_t    wr_data;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_a;
    word_t    alu_b;
    alu_op_t  alu_op;
    br_op_t   br_op;
    word_t    alu_result;
    logic     br_taken;

    rv_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .wr_sel     (wr_sel),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .br_op      (br_op),
        .alu_result (alu_result),
        .br_taken   (br_taken),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halt       (halt)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .wr_sel   (wr_sel),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .br_op      (br_op),
        .alu_result (alu_result),
        .br_taken   (br_taken)
    );

endmodule

// File: verification/rv_mem_model.sv
//////////////////////////////
// Wishbone classic slave memory with 0 to 3 random wait states
// programs are written through preload while the core is in reset
//////////////////////////////
module rv_mem_model #(
    parameter int          WORDS = 1024,
    parameter int unsigned SEED  = 32'h6548
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  rv_pkg::addr_t wb_adr,
    input  rv_pkg::word_t wb_dat_w,
    output rv_pkg::word_t wb_dat_r,
    output logic          wb_ack
);
    import rv_pkg::*;

    localparam int IW = $clog2(WORDS);

    word_t         mem [WORDS];
    logic [IW-1:0] idx;
    int unsigned   wait_left;

    assign idx = wb_adr[IW+1:2];

    // fill words carry the word index and decode as an illegal opcode
    task automatic clear_all();
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = word_t'(i << 7) | 32'h7f;
        end
    endtask

    task automatic preload(input int index, input word_t value);
        mem[index] = value;
    endtask

    initial begin
        wb_ack   <= 1'b0;
        wb_dat_r <= '0;
        void'($urandom(SEED));
        wait_left = $urandom % 4;
        forever begin
            @(posedge clk or posedge rst);
            wb_ack <= 1'b0;
            // ack lasts one cycle, the master drops the request on that edge
            if (!rst && wb_cyc && wb_stb && !wb_ack) begin
                if (wait_left == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_r <= mem[idx];
                    if (wb_we) begin
                        mem[idx] = wb_dat_w;
                    end
                    wait_left = $urandom % 4;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

// File: verification/rv_core_tb.sv
//////////////////////////////
// directed tests for tiny_rv with programs run from the memory model
// each test compares the words stored to the output port
//////////////////////////////
module rv_core_tb;

    localparam int TESTS       = 6;
    localparam int TEST_CYCLES = 2000;
    localparam int HALT_LIMIT  = 1500;

    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam int         OUT_AT     = 1000;
    localparam int         HALT_AT    = 1004;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    logic [31:0] prog[$];
    logic [31:0] expected[$];
    logic [31:0] seen[$];
    int          errors;
    int          checks;

    rv_core #(
        .RESET_PC (32'd0)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    rv_mem_model #(
        .WORDS (1024),
        .SEED  (32'h6548)
    ) u_mem (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    // instruction encoders for the RV32I field layouts
    function automatic logic [31:0] i_type(input logic [6:0] opc, input int rd,
                                           input logic [2:0] f3, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_REG};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog.push_back(word);
    endfunction

    // store a register to the output port
    function automatic void show_reg(input int rs);
        emit(sw(rs, 0, OUT_AT));
    endfunction

    function automatic void end_program();
        emit(sw(0, 0, HALT_AT));
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    // load prog under reset, run until halt and compare the outputs
    task automatic run_program(input string name, output bit halted);
        int cycles;
        seen.delete();
        @(posedge clk);
        rst <= 1'b1;
        u_mem.clear_all();
        foreach (prog[i]) begin
            u_mem.preload(i, prog[i]);
        end
        repeat (9) @(posedge clk);
        @(negedge clk);
        if (wb_cyc || wb_stb || wb_we || out_valid || halt) begin
            $display("%s: bus or output active while reset is held", name);
            errors++;
        end
        @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        halted = 1'b0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            if (out_valid) begin
                seen.push_back(out_data);
            end
            halted = halt;
            cycles++;
        end
        if (!halted) begin
            $display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
            errors++;
        end
        if (seen.size() != expected.size()) begin
            $display("%s: expected %0d outputs but saw %0d", name, expected.size(), seen.size());
            errors++;
        end
        foreach (expected[i]) begin
            if (i < seen.size()) begin
                check_value(name, expected[i], seen[i]);
            end
        end
    endtask

    task automatic arith_results();
        logic [31:0] a;
        logic [31:0] b;
        bit          halted;
        prog.delete();
        expected.delete();
        a = -7;
        b = 5;
        emit(i_type(OPC_IMM, 1, 3'b000, 0, -7));
        emit(i_type(OPC_IMM, 2, 3'b000, 0, 5));
        show_reg(1);
        emit(r_type(7'b0100000, 3'b000, 3, 2, 1));
        show_reg(3);
        emit(r_type(7'b0, 3'b010, 4, 1, 2));
        show_reg(4);
        emit(r_type(7'b0, 3'b011, 5, 1, 2));
        show_reg(5);
        // srai by 1 with the funct7 bits in the immediate
        emit(i_type(OPC_IMM, 6, 3'b101, 1, 32'h401));
        show_reg(6);
        emit(i_type(OPC_IMM, 7, 3'b101, 1, 28));
        show_reg(7);
        emit(i_type(OPC_IMM, 8, 3'b001, 2, 3));
        show_reg(8);
        emit(r_type(7'b0100000, 3'b101, 9, 1, 2));
        show_reg(9);
        emit(r_type(7'b0, 3'b100, 10, 1, 2));
        show_reg(10);
        emit(r_type(7'b0, 3'b110, 11, 1, 2));
        show_reg(11);
        emit(i_type(OPC_IMM, 12, 3'b111, 1, 32'h0f0));
        show_reg(12);
        emit(r_type(7'b0, 3'b000, 13, 1, 2));
        show_reg(13);
        end_program();
        expected.push_back(a);
        expected.push_back(b - a);
        expected.push_back({31'b0, $signed(a) < $signed(b)});
        expected.push_back({31'b0, a < b});
        expected.push_back($signed(a) >>> 1);
        expected.push_back(a >> 28);
        expected.push_back(b << 3);
        expected.push_back($signed(a) >>> b[4:0]);
        expected.push_back(a ^ b);
        expected.push_back(a | b);
        expected.push_back(a & 32'h0f0);
        expected.push_back(a + b);
        run_program("arith", halted);
    endtask

    task automatic memory_round_trip();
        logic [31:0] a;
        logic [31:0] b;
        bit          halted;
        prog.delete();
        expected.delete();
        a = 32'h1234_5678;
        b = -100;
        // data block at byte 0x400 which is word 256
        emit(i_type(OPC_IMM, 1, 3'b000, 0, 32'h400));
        emit(u_type(OPC_LUI, 2, 32'h12345));
        emit(i_type(OPC_IMM, 2, 3'b000, 2, 32'h678));
        emit(i_type(OPC_IMM, 3, 3'b000, 0, -100));
        emit(i_type(OPC_IMM, 4, 3'b100, 2, -1));
        emit(sw(2, 1, 0));
        emit(sw(3, 1, 4));
        emit(sw(4, 1, 8));
        emit(i_type(OPC_IMM, 8, 3'b000, 1, 16));
        emit(sw(3, 8, -4));
        emit(i_type(OPC_LOAD, 5, 3'b010, 1, 8));
        emit(i_type(OPC_LOAD, 6, 3'b010, 1, 0));
        emit(i_type(OPC_LOAD, 7, 3'b010, 1, 4));
        emit(i_type(OPC_LOAD, 9, 3'b010, 8, -4));
        show_reg(5);
        show_reg(6);
        show_reg(7);
        show_reg(9);
        end_program();
        expected.push_back(~a);
        expected.push_back(a);
        expected.push_back(b);
        expected.push_back(b);
        run_program("memory", halted);
        check_value("memory", a, u_mem.mem[256]);
        check_value("memory", b, u_mem.mem[257]);
        check_value("memory", ~a, u_mem.mem[258]);
        check_value("memory", b, u_mem.mem[259]);
    endtask

    task automatic branch_paths();
        logic [31:0] m;
        logic [31:0] p;
        logic [31:0] sum;
        logic [31:0] flags;
        bit          halted;
        prog.delete();
        expected.delete();
        m = 32'hffff_ffff;
        p = 32'd1;
        emit(i_type(OPC_IMM, 1, 3'b000, 0, 5));
        emit(i_type(OPC_IMM, 2, 3'b000, 0, 0));
        emit(r_type(7'b0, 3'b000, 2, 2, 1));
        emit(i_type(OPC_IMM, 1, 3'b000, 1, -1));
        emit(b_type(3'b001, 1, 0, -8));
        show_reg(2);
        emit(i_type(OPC_IMM, 3, 3'b000, 0, -1));
        emit(i_type(OPC_IMM, 4, 3'b000, 0, 1));
        emit(i_type(OPC_IMM, 5, 3'b000, 0, 0));
        // each branch skips one ori when taken
        emit(b_type(3'b100, 3, 4, 8));
        emit(i_type(OPC_IMM, 5, 3'b110, 5, 1));
        emit(b_type(3'b110, 3, 4, 8));
        emit(i_type(OPC_IMM, 5, 3'b110, 5, 2));
        emit(b_type(3'b101, 4, 3, 8));
        emit(i_type(OPC_IMM, 5, 3'b110, 5, 4));
        emit(b_type(3'b111, 4, 3, 8));
        emit(i_type(OPC_IMM, 5, 3'b110, 5, 8));
        emit(b_type(3'b000, 3, 4, 8));
        emit(i_type(OPC_IMM, 5, 3'b110, 5, 16));
        show_reg(5);
        end_program();
        sum = 0;
        for (int n = 5; n > 0; n--) begin
            sum = sum + n;
        end
        flags = 0;
        if (!($signed(m) < $signed(p))) flags = flags | 1;
        if (!(m < p)) flags = flags | 2;
        if (!($signed(p) >= $signed(m))) flags = flags | 4;
        if (!(p >= m)) flags = flags | 8;
        if (!(m == p)) flags = flags | 16;
        expected.push_back(sum);
        expected.push_back(flags);
        run_program("branches", halted);
    endtask

    task automatic jump_links();
        bit halted;
        prog.delete();
        expected.delete();
        emit(u_type(OPC_LUI, 1, 32'habcde));
        show_reg(1);
        emit(u_type(OPC_AUIPC, 2, 1));
        show_reg(2);
        emit(j_type(3, 12));
        emit(i_type(OPC_IMM, 5, 3'b000, 0, 99));
        show_reg(5);
        show_reg(3);
        // jalr from an odd base clears bit 0 of the target that auipc then reports
        emit(i_type(OPC_IMM, 6, 3'b000, 0, 49));
        emit(i_type(OPC_JALR, 7, 3'b000, 6, 4));
        show_reg(6);
        show_reg(6);
        show_reg(6);
        emit(u_type(OPC_AUIPC, 8, 0));
        show_reg(8);
        show_reg(7);
        end_program();
        expected.push_back(32'habcde << 12);
        expected.push_back(32'd8 + (32'd1 << 12));
        expected.push_back(32'd16 + 32'd4);
        expected.push_back((32'd49 + 32'd4) & ~32'd1);
        expected.push_back(32'd36 + 32'd4);
        run_program("jumps", halted);
    endtask

    task automatic halt_stays_quiet();
        bit halted;
        bit quiet;
        prog.delete();
        expected.delete();
        emit(i_type(OPC_IMM, 1, 3'b000, 0, 3));
        show_reg(1);
        end_program();
        show_reg(1);
        show_reg(1);
        expected.push_back(32'd3);
        run_program("halt", halted);
        quiet = 1'b1;
        if (halted) begin
            repeat (50) begin
                @(negedge clk);
                if (wb_cyc || out_valid || !halt) begin
                    quiet = 1'b0;
                end
            end
        end
        if (!quiet) begin
            $display("halt: bus or output activity seen after the core halted");
            errors++;
        end
    endtask

    task automatic illegal_opcode_halts();
        bit halted;
        prog.delete();
        expected.delete();
        emit(i_type(OPC_IMM, 0, 3'b000, 0, 5));
        emit(i_type(OPC_IMM, 1, 3'b000, 0, 7));
        show_reg(0);
        show_reg(1);
        // custom-0 opcode is not part of the core
        emit(32'h0000_000b);
        show_reg(1);
        end_program();
        expected.push_back(32'd0);
        expected.push_back(32'd7);
        run_program("illegal", halted);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TESTS * TEST_CYCLES) @(posedge clk);
        $display("watchdog: run exceeded %0d cycles", TESTS * TEST_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst <= 1'b1;
        errors = 0;
        checks = 0;
        arith_results();
        memory_round_trip();
        branch_paths();
        jump_links();
        halt_stays_quiet();
        illegal_opcode_halts();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tiny_rv.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_control.sv
design/rv_core.sv
verification/rv_mem_model.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the tiny_rv testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
    -f tiny_rv.f --Mdir obj_dir -o rv_core_tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rv_core_tb_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
